//--- verilog.f
rtl/ooo_pkg.sv
rtl/fu_alu.sv
rtl/fu_mult.sv
rtl/cdb_arbiter.sv
rtl/rob.sv
rtl/halt_status.sv
rtl/ooo_core.sv
dv/ooo_core_props.sv
dv/ooo_core_tb.sv

//--- dv/ooo_core_tb.sv
/*
 * Testbench for the completion and retirement core. Dispatches ALU,
 * multiply, branch, halt and illegal ops, keeps an in-order model of the
 * expected commits, and checks the commit stream with assertions.
 */
`timescale 1ns/1ns
module ooo_core_tb;
	import ooo_pkg::*;

	localparam int N_TESTS         = 6;
	localparam int CYCLES_PER_TEST = 2000;
	localparam int EXP_SIZE        = 512;	// more than any run commits

	logic            clock, arst_n;
	logic            disp_valid, disp_ready, redirect_valid;
	disp_op_t        disp_op;
	commit_pkt_t     commit0, commit1;
	logic [XLEN-1:0] redirect_pc;
	error_code_t     error_status;
	logic [31:0]     retired_count;

	// expected commits in program order
	commit_pkt_t     exp_mem   [EXP_SIZE];
	logic            exp_taken [EXP_SIZE];	// commit must redirect
	logic [XLEN-1:0] exp_tgt   [EXP_SIZE];
	int              exp_wr, exp_rd;
	logic            shadow;	// younger than a taken branch or a halt
	error_code_t     exp_err;
	logic [XLEN-1:0] next_pc;
	int              err_count, tests_run, total;

	ooo_core #(.ROB_DEPTH(8), .MULT_STAGES(4)) i_ooo_core (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// commits seen so far, also the read pointer of the model
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			exp_rd <= 0;
		else
			exp_rd <= exp_rd + int'(commit0.valid) + int'(commit1.valid);
	end

	always @(negedge clock) begin
		if (redirect_valid)
			shadow = 1'b0;	// wrong path gone, later ops are real again
	end

	task automatic flag_error(input string msg);
		err_count++;
		$display("** Error at %0t: %s", $time, msg);
	endtask

	////////////////////
	// checks
	////////////////////
	a_commit0: assert property (@(posedge clock) disable iff (!arst_n)
		commit0.valid |-> exp_rd < exp_wr && commit0 == exp_mem[exp_rd])
		else flag_error("commit0 differs from the next expected op");

	a_commit1: assert property (@(posedge clock) disable iff (!arst_n)
		commit1.valid |-> exp_rd + 1 < exp_wr && commit1 == exp_mem[exp_rd + 1])
		else flag_error("commit1 differs from the expected op");

	a_redirect: assert property (@(posedge clock) disable iff (!arst_n)
		commit0.valid |-> redirect_valid == exp_taken[exp_rd]
			&& (!exp_taken[exp_rd] || redirect_pc == exp_tgt[exp_rd]))
		else flag_error("redirect does not match the committed branch");

	a_error_code: assert property (@(posedge clock) disable iff (!arst_n)
		commit0.valid && commit0.kind != OP_NORMAL |=> error_status == exp_err)
		else flag_error("wrong error_status after a halting commit");

	a_count: assert property (@(posedge clock) disable iff (!arst_n)
		retired_count == 32'(exp_rd))
		else flag_error("retired_count differs from commits observed");

	////////////////////
	// model and driver
	////////////////////
	function automatic void record_expected(input disp_op_t op);
		commit_pkt_t e;
		logic        is_br;
		e     = '0;
		is_br = op.kind == OP_NORMAL && op.fu_sel == FU_ALU && op.alu_func == ALU_BEQ;
		if (shadow)
			return;	// never commits
		e.valid = 1'b1;
		e.pc    = op.pc;
		e.dest  = op.dest;
		e.kind  = op.kind;
		e.wr_en = op.dest != ZERO_REG && !is_br;
		if (op.kind == OP_NORMAL && op.fu_sel == FU_MULT)
			e.value = op.opa * op.opb;	// low half only
		else if (op.kind == OP_NORMAL) begin
			case (op.alu_func)
				ALU_ADD: e.value = op.opa + op.opb;
				ALU_SUB: e.value = op.opa - op.opb;
				ALU_AND: e.value = op.opa & op.opb;
				ALU_OR:  e.value = op.opa | op.opb;
				default: e.value = '0;	// branch
			endcase
		end
		exp_mem[exp_wr]   = e;
		exp_taken[exp_wr] = is_br && op.opa == op.opb;
		exp_tgt[exp_wr]   = op.pc + 64'd4 + op.opb;
		exp_wr++;
		if (op.kind != OP_NORMAL)
			exp_err = (op.kind == OP_HALT) ? HALTED_ON_HALT : HALTED_ON_ILLEGAL;
		shadow = exp_taken[exp_wr - 1] || op.kind != OP_NORMAL;
	endfunction

	function automatic disp_op_t make_op(input fu_sel_t fu, input alu_func_t f,
		input op_kind_t k, input arn_t dest);
		disp_op_t op;
		op.pc       = next_pc;
		op.dest     = dest;
		op.fu_sel   = fu;
		op.alu_func = f;
		op.kind     = k;
		op.opa      = {$urandom, $urandom};
		op.opb      = {$urandom, $urandom};
		next_pc     = next_pc + 64'd4;
		return op;
	endfunction

	task automatic send(input disp_op_t op);
		@(negedge clock);
		disp_valid = 1'b0;
		while (!disp_ready) begin
			@(negedge clock);
		end
		disp_valid = 1'b1;
		disp_op    = op;
		record_expected(op);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clock);
			disp_valid = 1'b0;
		end
	endtask

	// every recorded op retired, then a quiet stretch
	task automatic drain();
		idle(1);
		while (exp_rd < exp_wr) begin
			@(negedge clock);
		end
		idle(10);
	endtask

	task automatic apply_reset();
		@(negedge clock);
		arst_n     = 1'b0;
		disp_valid = 1'b0;
		exp_wr     = 0;
		shadow     = 1'b0;
		exp_err    = NO_ERROR;
		repeat (4) @(negedge clock);
		arst_n = 1'b1;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		$display("test %0d %s: done, %0d failed checks so far", tests_run, name,
			err_count + i_ooo_core.i_ooo_core_props.fail_count);
	endtask

	////////////////////
	// tests
	////////////////////
	task automatic alu_sequence();
		repeat (40)
			send(make_op(FU_ALU, alu_func_t'($urandom_range(0, 3)), OP_NORMAL,
				arn_t'($urandom_range(0, 30))));
		drain();
		end_test("alu_sequence");
	endtask

	task automatic mult_interleave();
		repeat (3) begin
			repeat (4)
				send(make_op(FU_MULT, ALU_ADD, OP_NORMAL, arn_t'($urandom_range(0, 30))));
			repeat (5)
				send(make_op(FU_ALU, alu_func_t'($urandom_range(0, 3)), OP_NORMAL, 5'd7));
		end
		drain();
		end_test("mult_interleave");
	endtask

	task automatic taken_branch();
		disp_op_t op;
		send(make_op(FU_ALU, ALU_ADD, OP_NORMAL, 5'd3));
		op     = make_op(FU_ALU, ALU_BEQ, OP_NORMAL, 5'd4);
		op.opb = op.opa + 64'd1;	// falls through
		send(op);
		op     = make_op(FU_ALU, ALU_BEQ, OP_NORMAL, 5'd5);
		op.opb = 64'($urandom_range(0, 255)) << 2;
		op.opa = op.opb;	// taken
		send(op);
		repeat (6)
			send(make_op(FU_MULT, ALU_ADD, OP_NORMAL, 5'd9));
		drain();
		end_test("taken_branch");
	endtask

	task automatic zero_dest_writes();
		send(make_op(FU_ALU, ALU_OR, OP_NORMAL, ZERO_REG));
		send(make_op(FU_MULT, ALU_ADD, OP_NORMAL, ZERO_REG));
		send(make_op(FU_ALU, ALU_SUB, OP_NORMAL, 5'd0));
		send(make_op(FU_ALU, ALU_AND, OP_NORMAL, ZERO_REG));
		drain();
		end_test("zero_dest_writes");
	endtask

	task automatic halt_freeze(input op_kind_t k, input string name);
		send(make_op(FU_ALU, ALU_ADD, OP_NORMAL, 5'd1));
		send(make_op(FU_MULT, ALU_ADD, OP_NORMAL, 5'd2));
		send(make_op(FU_ALU, ALU_ADD, k, ZERO_REG));
		// younger ops sit in the rob behind the halt while the multiply runs
		repeat (2)
			send(make_op(FU_ALU, ALU_OR, OP_NORMAL, 5'd6));
		drain();
		idle(20);	// nothing may retire from here on
		end_test(name);
	endtask

	initial begin
		void'($urandom(32'h59b7caf5));
		arst_n     = 1'b0;
		disp_valid = 1'b0;
		disp_op    = '0;
		next_pc    = 64'h1000;
		err_count  = 0;
		tests_run  = 0;
		apply_reset();
		alu_sequence();
		mult_interleave();
		taken_branch();
		zero_dest_writes();
		halt_freeze(OP_HALT, "halt_freeze");
		apply_reset();	// halted core needs a fresh start
		halt_freeze(OP_ILLEGAL, "illegal_after_reset");
		total = err_count + i_ooo_core.i_ooo_core_props.fail_count;
		$display("tests run %0d, failed checks %0d", tests_run, total);
		if (total == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// watchdog
	initial begin
		repeat (N_TESTS * CYCLES_PER_TEST) @(posedge clock);
		$display("timeout: run did not finish within %0d cycles", N_TESTS * CYCLES_PER_TEST);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- dv/ooo_core_props.sv
/*
 * Protocol checks on the top-level ports of the core, bound into every
 * ooo_core instance. The testbench reads fail_count at the end of the run.
 */
`timescale 1ns/1ns
module ooo_core_props (
	input logic                 clock,
	input logic                 arst_n,
	input logic                 disp_valid,
	input logic                 disp_ready,
	input ooo_pkg::commit_pkt_t commit0,
	input ooo_pkg::commit_pkt_t commit1,
	input logic                 redirect_valid,
	input ooo_pkg::error_code_t error_status
);
	import ooo_pkg::*;

	int fail_count = 0;	// failed assertions since time zero

	////////////////////
	// dispatch side
	////////////////////
	a_disp_ready: assert property (@(posedge clock) disable iff (!arst_n)
		disp_valid |-> disp_ready)
		else begin
			fail_count++;
			$error("dispatch strobe while disp_ready is low");
		end

	////////////////////
	// commit side
	////////////////////
	a_commit_order: assert property (@(posedge clock) disable iff (!arst_n)
		commit1.valid |-> commit0.valid)	// second slot never alone
		else begin
			fail_count++;
			$error("commit1 valid without commit0");
		end

	a_frozen: assert property (@(posedge clock) disable iff (!arst_n)
		error_status != NO_ERROR |-> !commit0.valid && !commit1.valid)
		else begin
			fail_count++;
			$error("commit after retirement was frozen");
		end

	a_redirect: assert property (@(posedge clock) disable iff (!arst_n)
		redirect_valid |-> commit0.valid)	// redirect rides on the branch commit
		else begin
			fail_count++;
			$error("redirect without a commit");
		end

endmodule

bind ooo_core ooo_core_props i_ooo_core_props (.*);

//--- rtl/ooo_core.sv
/*
 * Top level of the completion and retirement core. Turns each dispatch
 * strobe into a ROB allocation plus an issue to the selected unit, and
 * ties the units, bus arbiter, ROB and status block together.
 */
`timescale 1ns/1ns
module ooo_core #(
	parameter int ROB_DEPTH   = ooo_pkg::ROB_DEPTH_DEF,
	parameter int MULT_STAGES = ooo_pkg::MULT_STAGES_DEF
) (
	input  logic                        clock,
	input  logic                        arst_n,
	input  logic                        disp_valid,
	input  ooo_pkg::disp_op_t           disp_op,
	output logic                        disp_ready,
	output ooo_pkg::commit_pkt_t        commit0,
	output ooo_pkg::commit_pkt_t        commit1,
	output logic                        redirect_valid,
	output logic [ooo_pkg::XLEN-1:0]    redirect_pc,
	output ooo_pkg::error_code_t        error_status,
	output logic [31:0]                 retired_count
);
	import ooo_pkg::*;

	if (ROB_DEPTH < 2 || ROB_DEPTH > ROB_DEPTH_MAX || (ROB_DEPTH & (ROB_DEPTH - 1)) != 0)
	begin : g_bad_rob_depth
		$error("ROB_DEPTH must be a power of two from 2 to %0d", ROB_DEPTH_MAX);
	end
	if (MULT_STAGES < 1 || XLEN % MULT_STAGES != 0) begin : g_bad_mult_stages
		$error("MULT_STAGES must divide %0d", XLEN);
	end

	logic     run_q;	// low in reset and for the first edge after
	logic     disp_fire, alu_req_valid, mult_req_valid;
	logic     rob_full, flush, halted;
	logic     alu_accept, mult_accept, alu_grant, mult_grant;
	rob_idx_t tail_idx;
	fu_req_t  fu_req;
	cdb_pkt_t alu_result, mult_result, cdb0, cdb1;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			run_q <= 1'b0;
		else
			run_q <= 1'b1;
	end

	////////////////////
	// dispatch
	////////////////////
	assign disp_ready = run_q && !rob_full && !flush && !halted && alu_accept && mult_accept;
	assign disp_fire  = disp_valid && disp_ready;

	// halt and illegal only take a rob entry
	assign alu_req_valid  = disp_fire && disp_op.kind == OP_NORMAL && disp_op.fu_sel == FU_ALU;
	assign mult_req_valid = disp_fire && disp_op.kind == OP_NORMAL && disp_op.fu_sel == FU_MULT;
	assign fu_req = '{rob_idx: tail_idx, alu_func: disp_op.alu_func, pc: disp_op.pc,
		opa: disp_op.opa, opb: disp_op.opb};

	////////////////////
	// units and bus
	////////////////////
	fu_alu i_fu_alu (
		.clock(clock), .arst_n(arst_n), .flush(flush),
		.req_valid(alu_req_valid), .req(fu_req), .grant(alu_grant),
		.accept(alu_accept), .result(alu_result)
	);

	fu_mult #(.MULT_STAGES(MULT_STAGES)) i_fu_mult (
		.clock(clock), .arst_n(arst_n), .flush(flush),
		.req_valid(mult_req_valid), .req(fu_req), .grant(mult_grant),
		.accept(mult_accept), .result(mult_result)
	);

	cdb_arbiter i_cdb_arbiter (
		.alu_result(alu_result), .mult_result(mult_result),
		.alu_grant(alu_grant), .mult_grant(mult_grant),
		.cdb0(cdb0), .cdb1(cdb1)
	);

	////////////////////
	// retirement
	////////////////////
	rob #(.ROB_DEPTH(ROB_DEPTH)) i_rob (
		.clock(clock), .arst_n(arst_n),
		.alloc(disp_fire), .alloc_op(disp_op),
		.cdb0(cdb0), .cdb1(cdb1), .halted(halted),
		.tail_idx(tail_idx), .full(rob_full), .flush(flush),
		.redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
		.commit0(commit0), .commit1(commit1)
	);

	halt_status i_halt_status (
		.clock(clock), .arst_n(arst_n),
		.commit0(commit0), .commit1(commit1),
		.halted(halted), .error_status(error_status), .retired_count(retired_count)
	);

endmodule

//--- rtl/halt_status.sv
/*
 * Retirement status. Latches the first halt or illegal op seen at commit
 * as a sticky error code and counts every retired entry.
 */
`timescale 1ns/1ns
module halt_status (
	input  logic                 clock,
	input  logic                 arst_n,
	input  ooo_pkg::commit_pkt_t commit0,
	input  ooo_pkg::commit_pkt_t commit1,
	output logic                 halted,
	output ooo_pkg::error_code_t error_status,
	output logic [31:0]          retired_count
);
	import ooo_pkg::*;

	error_code_t error_q;
	logic [31:0] retired_q;

	function automatic error_code_t kind_to_err(input op_kind_t k);
		return (k == OP_ILLEGAL) ? HALTED_ON_ILLEGAL : HALTED_ON_HALT;
	endfunction

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			error_q   <= NO_ERROR;
			retired_q <= '0;
		end else begin
			if (error_q == NO_ERROR) begin	// first one wins, then sticky
				if (commit0.valid && commit0.kind != OP_NORMAL)
					error_q <= kind_to_err(commit0.kind);
				else if (commit1.valid && commit1.kind != OP_NORMAL)
					error_q <= kind_to_err(commit1.kind);
			end
			retired_q <= retired_q + 32'(commit0.valid) + 32'(commit1.valid);
		end
	end

	assign halted        = (error_q != NO_ERROR);	// back to the rob
	assign error_status  = error_q;
	assign retired_count = retired_q;

endmodule

//--- rtl/rob.sv
/*
 * Circular reorder buffer. Allocates one entry per dispatch, marks
 * entries complete from the two bus lanes, retires up to two entries per
 * cycle in order, and flushes everything younger than a committing
 * mispredicted branch.
 */
`timescale 1ns/1ns
module rob #(
	parameter int ROB_DEPTH = 8
) (
	input  logic                        clock,
	input  logic                        arst_n,
	input  logic                        alloc,
	input  ooo_pkg::disp_op_t           alloc_op,
	input  ooo_pkg::cdb_pkt_t           cdb0,
	input  ooo_pkg::cdb_pkt_t           cdb1,
	input  logic                        halted,	// retirement frozen
	output ooo_pkg::rob_idx_t           tail_idx,	// tag for the op being dispatched
	output logic                        full,
	output logic                        flush,
	output logic                        redirect_valid,
	output logic [ooo_pkg::XLEN-1:0]    redirect_pc,
	output ooo_pkg::commit_pkt_t        commit0,
	output ooo_pkg::commit_pkt_t        commit1
);
	import ooo_pkg::*;

	localparam int PTR_W = $clog2(ROB_DEPTH);

	typedef logic [PTR_W-1:0] slot_t;
	typedef logic [PTR_W:0]   ptr_t;	// slot plus wrap bit

	ptr_t                 head_q, tail_q;
	slot_t                h0, h1, tail_slot;
	logic [ROB_DEPTH-1:0] valid_q, complete_q;
	logic [ROB_DEPTH-1:0] is_branch_q, mispredict_q;
	logic [XLEN-1:0]      pc_q     [ROB_DEPTH];
	arn_t                 dest_q   [ROB_DEPTH];
	op_kind_t             kind_q   [ROB_DEPTH];
	logic [XLEN-1:0]      value_q  [ROB_DEPTH];
	logic [XLEN-1:0]      target_q [ROB_DEPTH];
	cdb_pkt_t             lane     [2];
	logic                 c0, c1;	// commit head, commit head+1

	function automatic commit_pkt_t pack_commit(input slot_t s);
		commit_pkt_t p;
		p.valid = 1'b1;
		p.pc    = pc_q[s];
		p.dest  = dest_q[s];
		p.wr_en = (dest_q[s] != ZERO_REG) && !is_branch_q[s];	// branches write nothing
		p.value = value_q[s];
		p.kind  = kind_q[s];
		return p;
	endfunction

	assign tail_slot = tail_q[PTR_W-1:0];
	assign tail_idx  = rob_idx_t'(tail_slot);
	assign full      = (head_q[PTR_W] != tail_q[PTR_W]) && (head_q[PTR_W-1:0] == tail_slot);

	always_comb begin
		lane[0] = cdb0;
		lane[1] = cdb1;
	end

	////////////////////
	// commit select
	////////////////////
	always_comb begin
		h0 = head_q[PTR_W-1:0];
		h1 = h0 + 1'b1;	// wraps with the slot width
		c0 = valid_q[h0] && complete_q[h0] && !halted;
		// second slot only behind a plain op, and only a plain op itself
		c1 = c0 && kind_q[h0] == OP_NORMAL && !mispredict_q[h0]
			&& valid_q[h1] && complete_q[h1]
			&& kind_q[h1] == OP_NORMAL && !mispredict_q[h1];
		flush          = c0 && is_branch_q[h0] && mispredict_q[h0];
		redirect_valid = flush;
		redirect_pc    = flush ? target_q[h0] : '0;
		commit0        = c0 ? pack_commit(h0) : '0;
		commit1        = c1 ? pack_commit(h1) : '0;
	end

	////////////////////
	// pointers and flags
	////////////////////
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			head_q     <= '0;
			tail_q     <= '0;
			valid_q    <= '0;
			complete_q <= '0;
		end else if (flush) begin
			// branch retires alone, everything behind it is dropped
			valid_q <= '0;
			head_q  <= head_q + ptr_t'(1);
			tail_q  <= head_q + ptr_t'(1);
		end else begin
			if (alloc) begin
				valid_q[tail_slot]    <= 1'b1;
				complete_q[tail_slot] <= (alloc_op.kind != OP_NORMAL);	// halt/illegal never execute
				tail_q                <= tail_q + ptr_t'(1);
			end
			for (int l = 0; l < 2; l++) begin
				if (lane[l].valid && valid_q[slot_t'(lane[l].rob_idx)])
					complete_q[slot_t'(lane[l].rob_idx)] <= 1'b1;
			end
			if (c0)
				valid_q[h0] <= 1'b0;
			if (c1)
				valid_q[h1] <= 1'b0;
			head_q <= head_q + ptr_t'(c0) + ptr_t'(c1);
		end
	end

	// entry payload
	always_ff @(posedge clock) begin
		if (alloc) begin
			pc_q[tail_slot]         <= alloc_op.pc;
			dest_q[tail_slot]       <= alloc_op.dest;
			kind_q[tail_slot]       <= alloc_op.kind;
			is_branch_q[tail_slot]  <= alloc_op.kind == OP_NORMAL
				&& alloc_op.fu_sel == FU_ALU && alloc_op.alu_func == ALU_BEQ;
			mispredict_q[tail_slot] <= 1'b0;
			value_q[tail_slot]      <= '0;
			target_q[tail_slot]     <= '0;
		end
		for (int l = 0; l < 2; l++) begin
			if (lane[l].valid) begin
				value_q[slot_t'(lane[l].rob_idx)]      <= lane[l].value;
				mispredict_q[slot_t'(lane[l].rob_idx)] <= lane[l].mispredict;
				target_q[slot_t'(lane[l].rob_idx)]     <= lane[l].target;
			end
		end
	end

endmodule

//--- rtl/cdb_arbiter.sv
/*
 * Fixed-priority routing of unit results onto the two common data bus
 * lanes. The ALU owns lane 0 when it has a result, and the multiplier
 * takes whichever lane is left. Grants are one cycle wide.
 */
`timescale 1ns/1ns
module cdb_arbiter (
	input  ooo_pkg::cdb_pkt_t alu_result,
	input  ooo_pkg::cdb_pkt_t mult_result,
	output logic              alu_grant,
	output logic              mult_grant,
	output ooo_pkg::cdb_pkt_t cdb0,
	output ooo_pkg::cdb_pkt_t cdb1
);
	import ooo_pkg::*;

	logic lane0_busy;	// lane 0 already taken this cycle

	////////////////////
	// lane 0
	////////////////////
	always_comb begin
		cdb0       = '0;
		alu_grant  = 1'b0;
		lane0_busy = 1'b0;
		if (alu_result.valid) begin
			cdb0       = alu_result;	// alu first
			alu_grant  = 1'b1;
			lane0_busy = 1'b1;
		end else if (mult_result.valid) begin
			cdb0 = mult_result;	// alu idle, mult drops to lane 0
		end
	end

	////////////////////
	// lane 1 and mult
	////////////////////
	always_comb begin
		cdb1       = '0;
		mult_grant = 1'b0;
		if (mult_result.valid) begin
			mult_grant = 1'b1;
			if (lane0_busy) begin
				cdb1 = mult_result;	// alu holds lane 0
			end
		end
	end

endmodule

//--- rtl/fu_mult.sv
/*
 * Pipelined 64-bit multiplier. Each stage adds one slice of partial
 * products. The last stage is the bus holding register, and the whole
 * pipe freezes while that stage waits for a grant.
 */
`timescale 1ns/1ns
module fu_mult #(
	parameter int MULT_STAGES = 4
) (
	input  logic              clock,
	input  logic              arst_n,
	input  logic              flush,
	input  logic              req_valid,
	input  ooo_pkg::fu_req_t  req,
	input  logic              grant,
	output logic              accept,
	output ooo_pkg::cdb_pkt_t result
);
	import ooo_pkg::*;

	localparam int LAST  = MULT_STAGES - 1;
	localparam int CHUNK = XLEN / MULT_STAGES;	// multiplier bits per stage

	logic [MULT_STAGES-1:0] vld_q;
	rob_idx_t               idx_q    [MULT_STAGES];
	logic [XLEN-1:0]        prod_q   [MULT_STAGES];	// running partial product
	logic [XLEN-1:0]        mcand_q  [MULT_STAGES];	// multiplicand, pre-shifted
	logic [XLEN-1:0]        mplier_q [MULT_STAGES];	// multiplier bits still to use
	logic                   stall;

	assign stall  = vld_q[LAST] && !grant;	// finished op stuck at the bus
	assign accept = !stall;

	////////////////////
	// valid shift chain
	////////////////////
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			vld_q <= '0;
		end else if (flush) begin
			vld_q <= '0;
		end else if (!stall) begin
			vld_q[0] <= req_valid;
			for (int s = 1; s < MULT_STAGES; s++)
				vld_q[s] <= vld_q[s-1];
		end
	end

	// datapath, low 64 bits of the product only
	always_ff @(posedge clock) begin
		if (!stall) begin
			idx_q[0]    <= req.rob_idx;
			prod_q[0]   <= req.opa * req.opb[CHUNK-1:0];
			mcand_q[0]  <= req.opa << CHUNK;
			mplier_q[0] <= req.opb >> CHUNK;
			for (int s = 1; s < MULT_STAGES; s++) begin
				idx_q[s]    <= idx_q[s-1];
				prod_q[s]   <= prod_q[s-1] + mcand_q[s-1] * mplier_q[s-1][CHUNK-1:0];
				mcand_q[s]  <= mcand_q[s-1] << CHUNK;
				mplier_q[s] <= mplier_q[s-1] >> CHUNK;
			end
		end
	end

	always_comb begin
		result            = '0;
		result.valid      = vld_q[LAST];
		result.rob_idx    = idx_q[LAST];
		result.value      = prod_q[LAST];
		result.mispredict = 1'b0;	// never a branch
	end

endmodule

//--- rtl/fu_alu.sv
/*
 * Single-cycle integer ALU with branch resolution. The result sits in a
 * holding register and is offered on the bus until the arbiter grants it.
 */
`timescale 1ns/1ns
module fu_alu (
	input  logic              clock,
	input  logic              arst_n,
	input  logic              flush,	// drop the held result
	input  logic              req_valid,
	input  ooo_pkg::fu_req_t  req,
	input  logic              grant,	// bus took the held result this cycle
	output logic              accept,
	output ooo_pkg::cdb_pkt_t result
);
	import ooo_pkg::*;

	cdb_pkt_t alu_pkt;	// result computed this cycle
	cdb_pkt_t hold_q;	// payload of the holding register
	logic     hold_valid_q;

	////////////////////
	// execute
	////////////////////
	always_comb begin
		alu_pkt         = '0;
		alu_pkt.valid   = 1'b1;
		alu_pkt.rob_idx = req.rob_idx;	// rob index is the tag
		case (req.alu_func)
			ALU_ADD: alu_pkt.value = req.opa + req.opb;
			ALU_SUB: alu_pkt.value = req.opa - req.opb;
			ALU_AND: alu_pkt.value = req.opa & req.opb;
			ALU_OR:  alu_pkt.value = req.opa | req.opb;
			ALU_BEQ: begin
				// not-taken prediction, so a taken branch is a mispredict
				alu_pkt.mispredict = (req.opa == req.opb);
				alu_pkt.target     = req.pc + 64'd4 + req.opb;
			end
			default: alu_pkt.value = '0;
		endcase
	end

	// free slot, or the held result leaves this cycle
	assign accept = !hold_valid_q || grant;

	////////////////////
	// holding register
	////////////////////
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			hold_valid_q <= 1'b0;
		end else if (flush) begin
			hold_valid_q <= 1'b0;	// younger than the branch, gone
		end else if (req_valid && accept) begin
			hold_valid_q <= 1'b1;
		end else if (grant) begin
			hold_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (req_valid && accept)
			hold_q <= alu_pkt;
	end

	always_comb begin
		result       = hold_q;
		result.valid = hold_valid_q;
	end

endmodule

//--- rtl/ooo_pkg.sv
/*
 * Shared sizes, encodings and packet types for the out-of-order
 * completion and retirement core. Every RTL and testbench file imports
 * this package inside its module body.
 */
package ooo_pkg;

	////////////////////
	// sizes
	////////////////////
	localparam int XLEN            = 64;	// data and pc width
	localparam int ARF_SIZE        = 32;	// architectural registers
	localparam int ROB_DEPTH_DEF   = 8;
	localparam int ROB_DEPTH_MAX   = 16;	// largest depth the index can name
	localparam int MULT_STAGES_DEF = 4;

	typedef logic [$clog2(ARF_SIZE)-1:0]      arn_t;
	typedef logic [$clog2(ROB_DEPTH_MAX)-1:0] rob_idx_t;	// doubles as the result tag

	localparam arn_t ZERO_REG = 5'd31;	// writes here are dropped

	////////////////////
	// encodings
	////////////////////
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_BEQ		// branch if opa == opb, predicted not taken
	} alu_func_t;

	typedef enum logic {
		FU_ALU,
		FU_MULT
	} fu_sel_t;

	typedef enum logic [1:0] {
		OP_NORMAL,
		OP_HALT,
		OP_ILLEGAL
	} op_kind_t;

	typedef enum logic [1:0] {
		NO_ERROR,
		HALTED_ON_HALT,
		HALTED_ON_ILLEGAL
	} error_code_t;

	////////////////////
	// packets
	////////////////////
	typedef struct packed {
		logic [XLEN-1:0] pc;
		arn_t            dest;
		fu_sel_t         fu_sel;
		alu_func_t       alu_func;
		op_kind_t        kind;
		logic [XLEN-1:0] opa;
		logic [XLEN-1:0] opb;
	} disp_op_t;

	typedef struct packed {
		rob_idx_t        rob_idx;
		alu_func_t       alu_func;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] opa;
		logic [XLEN-1:0] opb;
	} fu_req_t;

	typedef struct packed {
		logic            valid;
		rob_idx_t        rob_idx;
		logic [XLEN-1:0] value;
		logic            mispredict;	// taken branch, fetch went the wrong way
		logic [XLEN-1:0] target;
	} cdb_pkt_t;

	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] pc;
		arn_t            dest;
		logic            wr_en;
		logic [XLEN-1:0] value;
		op_kind_t        kind;
	} commit_pkt_t;

endpackage
